//--- verilog/rvCore_cfg.svh
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// data and address width
`define RV_XLEN 32

// architectural registers x0..x31
`define RV_REG_COUNT 32

`define RV_RESET_PC 32'h8000_0000

`endif

//--- verilog/rvCorePkg.sv
`include "rvCore_cfg.svh"

package rvCorePkg;

	typedef logic [`RV_XLEN-1:0] word_t;
	typedef logic [4:0] regIdx_t;
	typedef logic [3:0] aluOp_t;
	typedef logic [1:0] wbSel_t;
	typedef logic [1:0] memSize_t;
	typedef logic [3:0] byteMask_t;
	typedef logic [1:0] pcSel_t;

	// alu operations
	localparam aluOp_t ALU_ADD = 4'd0;
	localparam aluOp_t ALU_SUB = 4'd1;
	localparam aluOp_t ALU_SLL = 4'd2;
	localparam aluOp_t ALU_SLT = 4'd3;
	localparam aluOp_t ALU_SLTU = 4'd4;
	localparam aluOp_t ALU_XOR = 4'd5;
	localparam aluOp_t ALU_SRL = 4'd6;
	localparam aluOp_t ALU_SRA = 4'd7;
	localparam aluOp_t ALU_OR = 4'd8;
	localparam aluOp_t ALU_AND = 4'd9;
	// second operand straight through, used by lui
	localparam aluOp_t ALU_PASSB = 4'd10;

	localparam wbSel_t WB_ALU = 2'd0;
	localparam wbSel_t WB_LOAD = 2'd1;
	localparam wbSel_t WB_PC4 = 2'd2;
	localparam wbSel_t WB_PCIMM = 2'd3;

	// same encoding as funct3[1:0] of loads and stores
	localparam memSize_t MEM_BYTE = 2'd0;
	localparam memSize_t MEM_HALF = 2'd1;
	localparam memSize_t MEM_WORD = 2'd2;

	localparam pcSel_t PC_PLUS4 = 2'd0;
	localparam pcSel_t PC_IMM = 2'd1;
	localparam pcSel_t PC_ALU = 2'd2;

endpackage

//--- verilog/ctrlIf.sv
`timescale 1ns/100ps

interface ctrlIf;
	rvCorePkg::regIdx_t rs1;
	rvCorePkg::regIdx_t rs2;
	rvCorePkg::regIdx_t rd;
	rvCorePkg::aluOp_t aluOp;
	logic aluSrcImm;
	rvCorePkg::wbSel_t wbSel;
	logic regWrite;
	logic memRead;
	logic memWrite;
	rvCorePkg::memSize_t memSize;
	logic memUnsigned;
	logic isBranch;
	logic isJal;
	logic isJalr;

	modport decoder (output rs1, rs2, rd, aluOp, aluSrcImm, wbSel, regWrite,
		memRead, memWrite, memSize, memUnsigned, isBranch, isJal, isJalr);
	modport exec (input rs1, rs2, rd, aluOp, aluSrcImm, wbSel, regWrite,
		memRead, memWrite, memSize, memUnsigned, isBranch, isJal, isJalr);
	// register file only needs the indices and the write strobe
	modport rf (input rs1, rs2, rd, regWrite);
endinterface

//--- verilog/instDecoder.sv
`timescale 1ns/100ps

module instDecoder (
	input rvCorePkg::word_t inst,
	ctrlIf.decoder ctrl,
	output logic invalid,
	output logic ebreak
);
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic valid;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	// register fields come straight from the word
	assign ctrl.rs1 = inst[19:15];
	assign ctrl.rs2 = inst[24:20];
	assign ctrl.rd = inst[11:7];
	// access width and sign follow funct3 directly
	assign ctrl.memSize = rvCorePkg::memSize_t'(funct3[1:0]);
	assign ctrl.memUnsigned = funct3[2];
	assign invalid = ~valid;

	// alt is funct7[5] for R-type, sub and sra
	function automatic rvCorePkg::aluOp_t opFromFunct(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: return alt ? rvCorePkg::ALU_SUB : rvCorePkg::ALU_ADD;
			3'b001: return rvCorePkg::ALU_SLL;
			3'b010: return rvCorePkg::ALU_SLT;
			3'b011: return rvCorePkg::ALU_SLTU;
			3'b100: return rvCorePkg::ALU_XOR;
			3'b101: return alt ? rvCorePkg::ALU_SRA : rvCorePkg::ALU_SRL;
			3'b110: return rvCorePkg::ALU_OR;
			default: return rvCorePkg::ALU_AND;
		endcase
	endfunction

	always_comb begin
		valid = 1'b0;
		ebreak = 1'b0;
		ctrl.aluOp = rvCorePkg::ALU_ADD;
		ctrl.aluSrcImm = 1'b0;
		ctrl.wbSel = rvCorePkg::WB_ALU;
		ctrl.regWrite = 1'b0;
		ctrl.memRead = 1'b0;
		ctrl.memWrite = 1'b0;
		ctrl.isBranch = 1'b0;
		ctrl.isJal = 1'b0;
		ctrl.isJalr = 1'b0;
		case (opcode)
			7'b0110111: begin
				// lui
				valid = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp = rvCorePkg::ALU_PASSB;
			end
			7'b0010111: begin
				// auipc
				valid = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.wbSel = rvCorePkg::WB_PCIMM;
			end
			7'b1101111: begin
				valid = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.isJal = 1'b1;
				ctrl.wbSel = rvCorePkg::WB_PC4;
			end
			7'b1100111: begin
				if (funct3 == 3'b000) begin
					valid = 1'b1;
					ctrl.regWrite = 1'b1;
					ctrl.isJalr = 1'b1;
					ctrl.aluSrcImm = 1'b1;
					ctrl.wbSel = rvCorePkg::WB_PC4;
				end
			end
			7'b1100011: begin
				// beq only, compared through the alu zero flag
				if (funct3 == 3'b000) begin
					valid = 1'b1;
					ctrl.isBranch = 1'b1;
					ctrl.aluOp = rvCorePkg::ALU_SUB;
				end
			end
			7'b0000011: begin
				if (funct3 != 3'b011 && funct3 != 3'b110 && funct3 != 3'b111) begin
					valid = 1'b1;
					ctrl.regWrite = 1'b1;
					ctrl.memRead = 1'b1;
					ctrl.aluSrcImm = 1'b1;
					ctrl.wbSel = rvCorePkg::WB_LOAD;
				end
			end
			7'b0100011: begin
				if (funct3[2] == 1'b0 && funct3[1:0] != 2'b11) begin
					valid = 1'b1;
					ctrl.memWrite = 1'b1;
					ctrl.aluSrcImm = 1'b1;
				end
			end
			7'b0010011: begin
				// no shift immediates
				if (funct3 != 3'b001 && funct3 != 3'b101) begin
					valid = 1'b1;
					ctrl.regWrite = 1'b1;
					ctrl.aluSrcImm = 1'b1;
					ctrl.aluOp = opFromFunct(funct3, 1'b0);
				end
			end
			7'b0110011: begin
				if (funct7 == 7'b0000000 ||
						(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
					valid = 1'b1;
					ctrl.regWrite = 1'b1;
					ctrl.aluOp = opFromFunct(funct3, funct7[5]);
				end
			end
			7'b1110011: begin
				if (inst == 32'h0010_0073) begin
					valid = 1'b1;
					ebreak = 1'b1;
				end
			end
			default: begin
				valid = 1'b0;
			end
		endcase
	end
endmodule

//--- verilog/immGen.sv
`timescale 1ns/100ps

module immGen (
	input rvCorePkg::word_t inst,
	output rvCorePkg::word_t imm
);
	logic [6:0] opcode;

	assign opcode = inst[6:0];

	always_comb begin
		case (opcode)
			// I format: loads, op-imm, jalr
			7'b0000011, 7'b0010011, 7'b1100111: begin
				imm = {{20{inst[31]}}, inst[31:20]};
			end
			7'b0100011: begin
				imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			end
			// B format, offset in units of two bytes
			7'b1100011: begin
				imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
			end
			// U format, lui and auipc
			7'b0110111, 7'b0010111: begin
				imm = {inst[31:12], 12'b0};
			end
			7'b1101111: begin
				imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
			end
			default: begin
				imm = '0;
			end
		endcase
	end
endmodule

//--- verilog/regFile.sv
`timescale 1ns/100ps
`include "rvCore_cfg.svh"

module regFile (
	input logic clk,
	input logic arstN,
	ctrlIf.rf ctrl,
	input rvCorePkg::word_t wbData,
	output rvCorePkg::word_t rs1Data,
	output rvCorePkg::word_t rs2Data
);
	rvCorePkg::word_t regs [`RV_REG_COUNT];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `RV_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (ctrl.regWrite && ctrl.rd != '0) begin
			regs[ctrl.rd] <= wbData;
		end
	end

	// x0 always reads as zero
	assign rs1Data = (ctrl.rs1 == '0) ? '0 : regs[ctrl.rs1];
	assign rs2Data = (ctrl.rs2 == '0) ? '0 : regs[ctrl.rs2];
endmodule

//--- verilog/execUnit.sv
`timescale 1ns/100ps
`include "rvCore_cfg.svh"

module execUnit (
	input logic clk,
	input logic arstN,
	ctrlIf.exec ctrl,
	input rvCorePkg::word_t imm,
	input rvCorePkg::word_t rs1Data,
	input rvCorePkg::word_t rs2Data,
	input rvCorePkg::word_t dataRdata,
	output rvCorePkg::word_t pc,
	output rvCorePkg::word_t wbData,
	output rvCorePkg::word_t dataAddr,
	output rvCorePkg::word_t dataWdata,
	output rvCorePkg::byteMask_t dataWmask,
	output logic dataWrite,
	output logic dataRead
);
	rvCorePkg::word_t srcB;
	rvCorePkg::word_t aluResult;
	rvCorePkg::word_t pcPlus4;
	rvCorePkg::word_t pcImm;
	rvCorePkg::word_t nextPc;
	rvCorePkg::word_t laneWord;
	rvCorePkg::word_t loadData;
	rvCorePkg::pcSel_t pcSel;
	rvCorePkg::byteMask_t laneMask;
	logic [4:0] shamt;
	logic [1:0] byteOff;
	logic aluZero;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= `RV_RESET_PC;
		end else begin
			pc <= nextPc;
		end
	end

	assign srcB = ctrl.aluSrcImm ? imm : rs2Data;
	assign shamt = srcB[4:0];

	always_comb begin
		case (ctrl.aluOp)
			rvCorePkg::ALU_ADD: aluResult = rs1Data + srcB;
			rvCorePkg::ALU_SUB: aluResult = rs1Data - srcB;
			rvCorePkg::ALU_SLL: aluResult = rs1Data << shamt;
			rvCorePkg::ALU_SLT: aluResult = {{(`RV_XLEN-1){1'b0}}, $signed(rs1Data) < $signed(srcB)};
			rvCorePkg::ALU_SLTU: aluResult = {{(`RV_XLEN-1){1'b0}}, rs1Data < srcB};
			rvCorePkg::ALU_XOR: aluResult = rs1Data ^ srcB;
			rvCorePkg::ALU_SRL: aluResult = rs1Data >> shamt;
			rvCorePkg::ALU_SRA: aluResult = $signed(rs1Data) >>> shamt;
			rvCorePkg::ALU_OR: aluResult = rs1Data | srcB;
			rvCorePkg::ALU_AND: aluResult = rs1Data & srcB;
			rvCorePkg::ALU_PASSB: aluResult = srcB;
			default: aluResult = '0;
		endcase
	end

	// beq decodes to sub, so equal operands give zero
	assign aluZero = (aluResult == '0);
	assign pcPlus4 = pc + 32'd4;
	assign pcImm = pc + imm;

	always_comb begin
		if (ctrl.isJal || (ctrl.isBranch && aluZero)) begin
			pcSel = rvCorePkg::PC_IMM;
		end else if (ctrl.isJalr) begin
			pcSel = rvCorePkg::PC_ALU;
		end else begin
			pcSel = rvCorePkg::PC_PLUS4;
		end
	end

	always_comb begin
		case (pcSel)
			rvCorePkg::PC_IMM: nextPc = pcImm;
			rvCorePkg::PC_ALU: nextPc = {aluResult[`RV_XLEN-1:1], 1'b0};
			default: nextPc = pcPlus4;
		endcase
	end

	assign dataAddr = aluResult;
	assign byteOff = aluResult[1:0];
	assign dataRead = ctrl.memRead;
	assign dataWrite = ctrl.memWrite;

	// shift the addressed lane down to bit 0
	assign laneWord = dataRdata >> {byteOff, 3'b000};

	always_comb begin
		case (ctrl.memSize)
			rvCorePkg::MEM_BYTE: begin
				loadData = ctrl.memUnsigned ? {{(`RV_XLEN-8){1'b0}}, laneWord[7:0]}
					: {{(`RV_XLEN-8){laneWord[7]}}, laneWord[7:0]};
			end
			rvCorePkg::MEM_HALF: begin
				loadData = ctrl.memUnsigned ? {{(`RV_XLEN-16){1'b0}}, laneWord[15:0]}
					: {{(`RV_XLEN-16){laneWord[15]}}, laneWord[15:0]};
			end
			default: loadData = dataRdata;
		endcase
	end

	// store value repeated in every lane, mask picks the lanes
	always_comb begin
		case (ctrl.memSize)
			rvCorePkg::MEM_BYTE: begin
				dataWdata = {4{rs2Data[7:0]}};
				laneMask = 4'b0001 << byteOff;
			end
			rvCorePkg::MEM_HALF: begin
				dataWdata = {2{rs2Data[15:0]}};
				laneMask = 4'b0011 << {byteOff[1], 1'b0};
			end
			default: begin
				dataWdata = rs2Data;
				laneMask = 4'b1111;
			end
		endcase
	end

	assign dataWmask = ctrl.memWrite ? laneMask : '0;

	always_comb begin
		case (ctrl.wbSel)
			rvCorePkg::WB_LOAD: wbData = loadData;
			rvCorePkg::WB_PC4: wbData = pcPlus4;
			rvCorePkg::WB_PCIMM: wbData = pcImm;
			default: wbData = aluResult;
		endcase
	end
endmodule

//--- verilog/rvCore.sv
`timescale 1ns/100ps

module rvCore (
	input logic clk,
	input logic arstN,
	input rvCorePkg::word_t inst,
	input rvCorePkg::word_t dataRdata,
	output rvCorePkg::word_t pc,
	output rvCorePkg::word_t dataAddr,
	output rvCorePkg::word_t dataWdata,
	output rvCorePkg::byteMask_t dataWmask,
	output logic dataWrite,
	output logic dataRead,
	output logic invalid,
	output logic ebreak
);
	rvCorePkg::word_t imm;
	rvCorePkg::word_t rs1Data;
	rvCorePkg::word_t rs2Data;
	rvCorePkg::word_t wbData;

	ctrlIf ctrl ();

	// decoder and immediate generator both look at the raw word
	instDecoder instDecoder_i (
		.inst    (inst),
		.ctrl    (ctrl.decoder),
		.invalid (invalid),
		.ebreak  (ebreak)
	);

	immGen immGen_i (
		.inst (inst),
		.imm  (imm)
	);

	regFile regFile_i (
		.clk     (clk),
		.arstN   (arstN),
		.ctrl    (ctrl.rf),
		.wbData  (wbData),
		.rs1Data (rs1Data),
		.rs2Data (rs2Data)
	);

	execUnit execUnit_i (
		.clk       (clk),
		.arstN     (arstN),
		.ctrl      (ctrl.exec),
		.imm       (imm),
		.rs1Data   (rs1Data),
		.rs2Data   (rs2Data),
		.dataRdata (dataRdata),
		.pc        (pc),
		.wbData    (wbData),
		.dataAddr  (dataAddr),
		.dataWdata (dataWdata),
		.dataWmask (dataWmask),
		.dataWrite (dataWrite),
		.dataRead  (dataRead)
	);
endmodule

//--- test/rvCore_asserts.sv
`timescale 1ns/100ps

module rvCore_asserts (
	input logic clk,
	input logic arstN,
	input rvCorePkg::word_t pc,
	input rvCorePkg::byteMask_t dataWmask,
	input logic dataWrite,
	input logic dataRead,
	input logic invalid,
	input logic ebreak
);
	int failCount = 0;

	pcHalfAligned: assert property (@(posedge clk) disable iff (!arstN) pc[0] == 1'b0)
		else begin
			failCount++;
			$error("pc bit 0 is set");
		end

	readWriteExclusive: assert property (@(posedge clk) disable iff (!arstN)
			!(dataRead && dataWrite))
		else begin
			failCount++;
			$error("dataRead and dataWrite are high together");
		end

	writeHasMask: assert property (@(posedge clk) disable iff (!arstN)
			dataWrite |-> dataWmask != '0)
		else begin
			failCount++;
			$error("dataWrite is high with an empty byte mask");
		end

	invalidIsQuiet: assert property (@(posedge clk) disable iff (!arstN)
			invalid |-> !dataWrite && !ebreak)
		else begin
			failCount++;
			$error("invalid word drives dataWrite or ebreak");
		end
endmodule

//--- test/rvCoreChecker.sv
`timescale 1ns/100ps
`include "rvCore_cfg.svh"

module rvCoreChecker (
	input logic clk,
	input logic arstN,
	input rvCorePkg::word_t inst,
	input rvCorePkg::word_t dataRdata,
	input rvCorePkg::word_t pc,
	input rvCorePkg::word_t dataAddr,
	input rvCorePkg::word_t dataWdata,
	input rvCorePkg::byteMask_t dataWmask,
	input logic dataWrite,
	input logic dataRead,
	input logic invalid,
	input logic ebreak,
	output int errorCount
);
	rvCorePkg::word_t modelPc;
	rvCorePkg::word_t modelRegs [`RV_REG_COUNT];
	int errors = 0;

	assign errorCount = errors;

	task automatic compare(input string name, input rvCorePkg::word_t expected,
			input rvCorePkg::word_t actual);
		if (actual !== expected) begin
			errors++;
			$display("ERROR %s (inst %h at pc %h): expected %h, actual %h",
				name, inst, modelPc, expected, actual);
		end
	endtask

	// RV32I register-register and register-immediate arithmetic
	function automatic rvCorePkg::word_t computeAlu(input logic [2:0] funct3, input logic alt,
			input rvCorePkg::word_t x, input rvCorePkg::word_t y);
		case (funct3)
			3'd0: return alt ? x - y : x + y;
			3'd1: return x << y[4:0];
			3'd2: return {31'd0, $signed(x) < $signed(y)};
			3'd3: return {31'd0, x < y};
			3'd4: return x ^ y;
			3'd5: begin
				if (alt) begin
					return $signed(x) >>> y[4:0];
				end
				return x >> y[4:0];
			end
			3'd6: return x | y;
			default: return x & y;
		endcase
	endfunction

	// outputs are settled by the falling edge, commit happens on the next rising edge
	always @(negedge clk) begin
		logic [6:0] opcode;
		logic [2:0] funct3;
		logic [6:0] funct7;
		rvCorePkg::regIdx_t rd;
		rvCorePkg::word_t src1;
		rvCorePkg::word_t src2;
		rvCorePkg::word_t immI;
		rvCorePkg::word_t immS;
		rvCorePkg::word_t immB;
		rvCorePkg::word_t immU;
		rvCorePkg::word_t immJ;
		rvCorePkg::word_t addr;
		rvCorePkg::word_t lane;
		rvCorePkg::word_t result;
		rvCorePkg::word_t nextPc;
		rvCorePkg::word_t storeData;
		rvCorePkg::byteMask_t mask;
		logic isValid;
		logic doWrite;
		logic isLoad;
		logic isStore;
		if (!arstN) begin
			modelPc = `RV_RESET_PC;
			for (int i = 0; i < `RV_REG_COUNT; i++) begin
				modelRegs[i] = '0;
			end
		end else begin
			opcode = inst[6:0];
			funct3 = inst[14:12];
			funct7 = inst[31:25];
			rd = inst[11:7];
			src1 = modelRegs[inst[19:15]];
			src2 = modelRegs[inst[24:20]];
			immI = {{20{inst[31]}}, inst[31:20]};
			immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			immB = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
			immU = {inst[31:12], 12'd0};
			immJ = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
			isValid = 1'b1;
			doWrite = 1'b0;
			isLoad = 1'b0;
			isStore = 1'b0;
			addr = '0;
			lane = '0;
			result = '0;
			storeData = '0;
			mask = '0;
			nextPc = modelPc + 32'd4;
			case (opcode)
				7'b0110111: begin
					doWrite = 1'b1;
					result = immU;
				end
				7'b0010111: begin
					doWrite = 1'b1;
					result = modelPc + immU;
				end
				7'b1101111: begin
					doWrite = 1'b1;
					result = modelPc + 32'd4;
					nextPc = modelPc + immJ;
				end
				7'b1100111: begin
					isValid = (funct3 == 3'd0);
					doWrite = 1'b1;
					result = modelPc + 32'd4;
					nextPc = (src1 + immI) & ~32'd1;
				end
				7'b1100011: begin
					isValid = (funct3 == 3'd0);
					if (src1 == src2) begin
						nextPc = modelPc + immB;
					end
				end
				7'b0000011: begin
					addr = src1 + immI;
					lane = dataRdata >> (8 * addr[1:0]);
					isLoad = 1'b1;
					doWrite = 1'b1;
					case (funct3)
						3'd0: result = {{24{lane[7]}}, lane[7:0]};
						3'd1: result = {{16{lane[15]}}, lane[15:0]};
						3'd2: result = dataRdata;
						3'd4: result = {24'd0, lane[7:0]};
						3'd5: result = {16'd0, lane[15:0]};
						default: isValid = 1'b0;
					endcase
				end
				7'b0100011: begin
					addr = src1 + immS;
					isStore = 1'b1;
					case (funct3)
						3'd0: begin
							mask = 4'b0001 << addr[1:0];
							storeData = {4{src2[7:0]}};
						end
						3'd1: begin
							mask = addr[1] ? 4'b1100 : 4'b0011;
							storeData = {2{src2[15:0]}};
						end
						3'd2: begin
							mask = 4'b1111;
							storeData = src2;
						end
						default: isValid = 1'b0;
					endcase
				end
				7'b0010011: begin
					isValid = (funct3 != 3'd1 && funct3 != 3'd5);
					doWrite = 1'b1;
					result = computeAlu(funct3, 1'b0, src1, immI);
				end
				7'b0110011: begin
					isValid = (funct7 == 7'd0) ||
						(funct7 == 7'b0100000 && (funct3 == 3'd0 || funct3 == 3'd5));
					doWrite = 1'b1;
					result = computeAlu(funct3, funct7[5], src1, src2);
				end
				7'b1110011: isValid = (inst == 32'h0010_0073);
				default: isValid = 1'b0;
			endcase
			// nothing but the pc step survives an invalid word
			if (!isValid) begin
				doWrite = 1'b0;
				isLoad = 1'b0;
				isStore = 1'b0;
				nextPc = modelPc + 32'd4;
			end
			compare("pc", modelPc, pc);
			compare("invalid", 32'(!isValid), 32'(invalid));
			compare("ebreak", 32'(inst == 32'h0010_0073), 32'(ebreak));
			compare("dataRead", 32'(isLoad), 32'(dataRead));
			compare("dataWrite", 32'(isStore), 32'(dataWrite));
			compare("dataWmask", 32'(isStore ? mask : 4'b0000), 32'(dataWmask));
			if (isLoad || isStore) begin
				compare("dataAddr", addr, dataAddr);
			end
			if (isStore) begin
				compare("dataWdata", storeData, dataWdata);
			end
			if (doWrite && rd != '0) begin
				modelRegs[rd] = result;
			end
			modelPc = nextPc;
		end
	end
endmodule

//--- test/rvCoreTb.sv
`timescale 1ns/100ps

module rvCoreTb;
	localparam int resetCycles = 5;
	localparam int instCount = 2000;
	// reset plus one cycle per instruction, with some slack
	localparam int cycleLimit = resetCycles + instCount + 95;

	logic clk = 1'b0;
	logic arstN;
	rvCorePkg::word_t inst;
	rvCorePkg::word_t dataRdata;
	rvCorePkg::word_t pc;
	rvCorePkg::word_t dataAddr;
	rvCorePkg::word_t dataWdata;
	rvCorePkg::byteMask_t dataWmask;
	logic dataWrite;
	logic dataRead;
	logic invalid;
	logic ebreak;
	int checkerErrors;
	int cycleCount = 0;
	logic [15:0] lfsrState = 16'd36925;
	rvCorePkg::word_t dataMem [512];

	always #10 clk = ~clk;

	rvCore rvCore_i (
		.clk       (clk),
		.arstN     (arstN),
		.inst      (inst),
		.dataRdata (dataRdata),
		.pc        (pc),
		.dataAddr  (dataAddr),
		.dataWdata (dataWdata),
		.dataWmask (dataWmask),
		.dataWrite (dataWrite),
		.dataRead  (dataRead),
		.invalid   (invalid),
		.ebreak    (ebreak)
	);

	rvCoreChecker rvCoreChecker_i (
		.clk        (clk),
		.arstN      (arstN),
		.inst       (inst),
		.dataRdata  (dataRdata),
		.pc         (pc),
		.dataAddr   (dataAddr),
		.dataWdata  (dataWdata),
		.dataWmask  (dataWmask),
		.dataWrite  (dataWrite),
		.dataRead   (dataRead),
		.invalid    (invalid),
		.ebreak     (ebreak),
		.errorCount (checkerErrors)
	);

	bind rvCore rvCore_asserts rvCoreAsserts_i (
		.clk       (clk),
		.arstN     (arstN),
		.pc        (pc),
		.dataWmask (dataWmask),
		.dataWrite (dataWrite),
		.dataRead  (dataRead),
		.invalid   (invalid),
		.ebreak    (ebreak)
	);

	// 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
	function automatic rvCorePkg::word_t takeBits(input int count);
		rvCorePkg::word_t bits;
		logic feedback;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			feedback = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
			lfsrState = {lfsrState[14:0], feedback};
			bits = {bits[30:0], feedback};
		end
		return bits;
	endfunction

	function automatic rvCorePkg::word_t randomInstruction();
		logic [3:0] kind;
		logic [2:0] funct3;
		logic [1:0] size;
		logic alt;
		logic unsignedLoad;
		rvCorePkg::regIdx_t rd;
		rvCorePkg::regIdx_t rs1;
		rvCorePkg::regIdx_t rs2;
		logic [4:0] step;
		logic [11:0] offset;
		logic [12:0] branchOff;
		logic [20:0] jumpOff;
		rvCorePkg::word_t word;
		kind = 4'(takeBits(4));
		funct3 = 3'(takeBits(3));
		// x0..x7 only, so results get reused often
		rd = {2'b00, 3'(takeBits(3))};
		rs1 = {2'b00, 3'(takeBits(3))};
		rs2 = {2'b00, 3'(takeBits(3))};
		step = 5'(takeBits(5));
		branchOff = {{6{step[4]}}, step, 2'b00};
		jumpOff = {{14{step[4]}}, step, 2'b00};
		size = 2'(takeBits(2));
		if (size == 2'd3) begin
			size = 2'd2;
		end
		// aligned, non-negative, inside the first 32 words
		offset = {5'd0, step, 2'b00};
		if (size == 2'd0) begin
			offset[1:0] = 2'(takeBits(2));
		end else if (size == 2'd1) begin
			offset[1] = 1'(takeBits(1));
		end
		case (kind)
			4'd0, 4'd1: begin
				// no shift immediates
				if (funct3 == 3'd1 || funct3 == 3'd5) begin
					funct3 = 3'd0;
				end
				word = {12'(takeBits(12)), rs1, funct3, rd, 7'b0010011};
			end
			4'd2: word = {20'(takeBits(20)), rd, 7'b0110111};
			4'd3: word = {20'(takeBits(20)), rd, 7'b0010111};
			4'd4, 4'd5: begin
				alt = 1'(takeBits(1)) && (funct3 == 3'd0 || funct3 == 3'd5);
				word = {1'b0, alt, 5'd0, rs2, rs1, funct3, rd, 7'b0110011};
			end
			4'd6, 4'd7: word = {offset[11:5], rs2, 5'd0, 1'b0, size, offset[4:0], 7'b0100011};
			4'd8, 4'd9: begin
				unsignedLoad = 1'(takeBits(1)) && size != 2'd2;
				word = {offset, 5'd0, unsignedLoad, size, rd, 7'b0000011};
			end
			4'd10: begin
				word = {branchOff[12], branchOff[10:5], rs2, rs1, 3'b000, branchOff[4:1],
					branchOff[11], 7'b1100011};
			end
			4'd11: word = {jumpOff[20], jumpOff[10:1], jumpOff[11], jumpOff[19:12], rd, 7'b1101111};
			4'd12: word = {12'(takeBits(12)), rs1, 3'b000, rd, 7'b1100111};
			4'd13: word = 32'h0010_0073;
			default: word = takeBits(32);
		endcase
		return word;
	endfunction

	// data memory, word addressed by dataAddr[10:2]
	assign dataRdata = dataMem[dataAddr[10:2]];

	always @(posedge clk) begin
		rvCorePkg::word_t merged;
		if (dataWrite) begin
			merged = dataMem[dataAddr[10:2]];
			for (int lane = 0; lane < 4; lane++) begin
				if (dataWmask[lane]) begin
					merged[8*lane +: 8] = dataWdata[8*lane +: 8];
				end
			end
			dataMem[dataAddr[10:2]] <= merged;
		end
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("timeout: run still going after %0d cycles", cycleLimit);
			$display("sim failed");
			$finish;
		end
	end

	initial begin
		int assertFails;
		arstN = 1'b0;
		// nop while in reset
		inst = 32'h0000_0013;
		for (int i = 0; i < 512; i++) begin
			dataMem[i] = {7'h5A, 9'(i), 7'h33, ~9'(i)};
		end
		repeat (resetCycles) @(posedge clk);
		arstN <= 1'b1;
		inst <= randomInstruction();
		for (int n = 1; n < instCount; n++) begin
			@(posedge clk);
			inst <= randomInstruction();
		end
		// last instruction commits on this edge
		@(posedge clk);
		#1;
		assertFails = rvCore_i.rvCoreAsserts_i.failCount;
		$display("checker errors: %0d, assertion failures: %0d", checkerErrors, assertFails);
		if (checkerErrors == 0 && assertFails == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end
endmodule

//--- list.f
+incdir+verilog
verilog/rvCorePkg.sv
verilog/ctrlIf.sv
verilog/instDecoder.sv
verilog/immGen.sv
verilog/regFile.sv
verilog/execUnit.sv
verilog/rvCore.sv
test/rvCore_asserts.sv
test/rvCoreChecker.sv
test/rvCoreTb.sv

//--- run.sh
#!/bin/bash
cd "$(dirname "$0")" \
	&& verilator --binary --assert --timescale 1ns/100ps --top-module rvCoreTb -f list.f \
	&& ./obj_dir/VrvCoreTb +verilator+error+limit+1000 | tee sim.log \
	&& ! grep -q "sim failed" sim.log \
	&& grep -q "sim passed" sim.log \
	|| { echo "simulation did not pass"; exit 1; }
